//--- verilog/uartRxPkg.sv
/* UART receive path shared definitions
   APB register map, status bit positions, self-test pattern and FSM states */
package uartRxPkg;

        ////////////////////////////////////////
        // APB register offsets
        localparam logic [11:0] ADDR_DATA   = 12'h000;      // Head of receive FIFO
        localparam logic [11:0] ADDR_STATUS = 12'h004;      // Flags and self-test result
        localparam logic [11:0] ADDR_CTRL   = 12'h008;      // Bit 0 starts self-test

        // Status word bit positions
        localparam int ST_EMPTY    = 0;
        localparam int ST_HALF     = 1;
        localparam int ST_FULL     = 2;
        localparam int ST_OVF      = 3;
        localparam int ST_FRAMEERR = 4;         // Sticky, cleared by STATUS read
        localparam int ST_BISTBUSY = 5;
        localparam int ST_BISTPASS = 6;
        localparam int ST_BISTDONE = 7;

        ////////////////////////////////////////
        // Self-test pattern, alternating and nibble edges
        localparam int BIST_LEN = 4;
        localparam logic [7:0] BIST_PATTERN [BIST_LEN] = '{8'h55, 8'hAA, 8'h0F, 8'hF0};

        typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxState_t;
        typedef enum logic [1:0] {BIST_IDLE, BIST_SEND, BIST_WAIT, BIST_DONE} bistState_t;

endpackage

//--- verilog/fifoPortIf.sv
/* FIFO read and status port
   Joins the receive FIFO head and flags to the register block */
`timescale 1ns/1ps
interface fifoPortIf #(
        parameter int dataBits = 8
);
        logic [dataBits-1:0] rdData;    // Head entry, combinational
        logic pop;                      // Removes the head at the clock edge
        logic empty;
        logic halfFull;
        logic full;
        logic overflow;                 // Push dropped since last pop

        modport fifo (output rdData, empty, halfFull, full, overflow, input pop);
        modport regs (input rdData, empty, halfFull, full, overflow, output pop);

endinterface

//--- verilog/uartRx.sv
/* UART serial receiver
   Synchronizes the line, samples mid-bit LSB first, flags bad stop bits */
`timescale 1ns/1ps
module uartRx #(
        parameter int dataBits = 8,
        parameter int clksPerBit = 16
) (
        input logic clk,
        input logic rst,
        input logic rxIn,
        output logic [dataBits-1:0] rxData,
        output logic rxValid,
        output logic frameErr
);
        import uartRxPkg::*;

        localparam int cntW = $clog2(clksPerBit);
        localparam int idxW = $clog2(dataBits);

        logic [1:0] rxSync;             // Two-flop synchronizer
        logic rxLast;                   // Previous synchronized level
        logic rxBit;
        logic bitEnd;                   // Last clock of a bit period
        logic [cntW-1:0] clkCnt;
        logic [idxW-1:0] bitIdx;
        logic [dataBits-1:0] shiftReg;
        rxState_t state;

        assign rxBit = rxSync[1];
        assign rxData = shiftReg;
        assign bitEnd = (clkCnt == cntW'(clksPerBit - 1));

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        rxSync <= 2'b11;                // Line idles high
                        rxLast <= 1'b1;
                end else begin
                        rxSync <= {rxSync[0], rxIn};
                        rxLast <= rxBit;
                end
        end

        ////////////////////////////////////////
        // Frame FSM
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        state <= RX_IDLE;
                        clkCnt <= '0;
                        bitIdx <= '0;
                        rxValid <= 1'b0;
                        frameErr <= 1'b0;
                end else begin
                        rxValid <= 1'b0;                // One-cycle pulses
                        frameErr <= 1'b0;
                        clkCnt <= clkCnt + 1'b1;
                        case (state)
                        RX_IDLE: begin
                                clkCnt <= '0;
                                if (rxLast && !rxBit)
                                        state <= RX_START;      // Falling edge of start bit
                        end
                        RX_START: if (clkCnt == cntW'(clksPerBit / 2 - 1)) begin
                                clkCnt <= '0;
                                bitIdx <= '0;
                                // High again at mid start bit is a glitch
                                state <= rxBit ? RX_IDLE : RX_DATA;
                        end
                        RX_DATA: if (bitEnd) begin
                                clkCnt <= '0;
                                bitIdx <= bitIdx + 1'b1;
                                if (bitIdx == idxW'(dataBits - 1))
                                        state <= RX_STOP;
                        end
                        RX_STOP: if (bitEnd) begin
                                clkCnt <= '0;
                                rxValid <= rxBit;               // Good stop bit
                                frameErr <= !rxBit;             // Byte is discarded
                                state <= RX_IDLE;
                        end
                        endcase
                end
        end

        // Data shift register, LSB arrives first
        always_ff @(posedge clk) begin
                if (state == RX_DATA && bitEnd)
                        shiftReg <= {rxBit, shiftReg[dataBits-1:1]};
        end

endmodule

//--- verilog/rxFifo.sv
/* Receive FIFO
   Circular buffer with empty, half-full, full and overflow flags; frozen in BIST */
`timescale 1ns/1ps
module rxFifo #(
        parameter int dataBits = 8,
        parameter int fifoWidth = 4
) (
        input logic clk,
        input logic rst,
        input logic [dataBits-1:0] pushData,
        input logic push,
        input logic freeze,
        fifoPortIf.fifo port
);
        localparam int depth = 2 ** fifoWidth;

        logic [dataBits-1:0] mem [depth];
        logic [fifoWidth-1:0] wrPtr;
        logic [fifoWidth-1:0] rdPtr;
        logic [fifoWidth:0] count;              // One extra bit to hold depth
        logic [fifoWidth:0] countNext;
        logic doPush;
        logic doPop;
        logic dropped;

        // Pop needs data, push needs room unless a pop frees a slot
        assign doPop = port.pop && !freeze && (count != '0);
        assign doPush = push && !freeze && ((count != (fifoWidth + 1)'(depth)) || doPop);
        assign dropped = push && !freeze && !doPush;
        assign countNext = count + (fifoWidth + 1)'(doPush) - (fifoWidth + 1)'(doPop);

        assign port.rdData = mem[rdPtr];        // Head shows through

        ////////////////////////////////////////
        // Pointers, count and registered flags
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                        port.empty <= 1'b1;
                        port.halfFull <= 1'b0;
                        port.full <= 1'b0;
                        port.overflow <= 1'b0;
                end else if (!freeze) begin     // Everything holds in BIST
                        if (doPush)
                                wrPtr <= wrPtr + 1'b1;
                        if (doPop)
                                rdPtr <= rdPtr + 1'b1;
                        count <= countNext;
                        port.empty <= (countNext == '0);
                        port.halfFull <= (countNext >= (fifoWidth + 1)'(depth / 2));
                        port.full <= (countNext == (fifoWidth + 1)'(depth));
                        if (dropped)
                                port.overflow <= 1'b1;          // Byte lost
                        else if (doPop)
                                port.overflow <= 1'b0;          // Reader caught up
                end
        end

        // Storage
        always_ff @(posedge clk) begin
                if (doPush)
                        mem[wrPtr] <= pushData;
        end

endmodule

//--- verilog/fifoBist.sv
/* Receive path self-test
   Serializes a fixed byte pattern into the receiver and checks each decoded byte */
`timescale 1ns/1ps
module fifoBist #(
        parameter int clksPerBit = 16
) (
        input logic clk,
        input logic rst,
        input logic start,
        input logic [7:0] rxData,
        input logic rxValid,
        input logic frameErr,
        output logic txd,
        output logic active,
        output logic done,
        output logic pass
);
        import uartRxPkg::*;

        localparam int cntW = $clog2(clksPerBit);
        localparam int idxW = $clog2(BIST_LEN);
        localparam int timeout = 20 * clksPerBit;       // Two frame times
        localparam int tmrW = $clog2(timeout + 1);

        bistState_t state;
        logic [cntW-1:0] clkCnt;
        logic [3:0] bitCnt;             // Start, 8 data, stop
        logic [idxW-1:0] byteIdx;
        logic [tmrW-1:0] timer;
        logic got;                      // Receiver answered for this byte
        logic [9:0] frame;

        assign frame = {1'b1, BIST_PATTERN[byteIdx], 1'b0};
        assign txd = (state == BIST_SEND) ? frame[bitCnt] : 1'b1;       // Idle high

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        state <= BIST_IDLE;
                        active <= 1'b0;
                        done <= 1'b0;
                        pass <= 1'b0;
                        clkCnt <= '0;
                        bitCnt <= '0;
                        byteIdx <= '0;
                        timer <= '0;
                        got <= 1'b0;
                end else begin
                        case (state)
                        BIST_IDLE, BIST_DONE: if (start) begin
                                state <= BIST_SEND;
                                active <= 1'b1;
                                done <= 1'b0;
                                pass <= 1'b1;           // Cleared by any failure
                                clkCnt <= '0;
                                bitCnt <= '0;
                                byteIdx <= '0;
                                got <= 1'b0;
                        end
                        BIST_SEND: begin
                                clkCnt <= clkCnt + 1'b1;
                                if (clkCnt == cntW'(clksPerBit - 1)) begin
                                        clkCnt <= '0;
                                        bitCnt <= bitCnt + 1'b1;
                                        if (bitCnt == 4'd9) begin       // Stop bit sent
                                                state <= BIST_WAIT;
                                                timer <= '0;
                                        end
                                end
                        end
                        BIST_WAIT: begin
                                timer <= timer + 1'b1;
                                if (got || timer == tmrW'(timeout)) begin
                                        if (!got)
                                                pass <= 1'b0;           // Timed out
                                        got <= 1'b0;
                                        bitCnt <= '0;
                                        byteIdx <= byteIdx + 1'b1;
                                        state <= BIST_SEND;
                                        if (byteIdx == idxW'(BIST_LEN - 1)) begin
                                                state <= BIST_DONE;
                                                active <= 1'b0;
                                                done <= 1'b1;
                                        end
                                end
                        end
                        endcase
                        // Decoded byte usually lands during our own stop bit
                        if (active && (rxValid || frameErr)) begin
                                got <= 1'b1;
                                if (frameErr || rxData != BIST_PATTERN[byteIdx])
                                        pass <= 1'b0;
                        end
                end
        end

endmodule

//--- verilog/apbRegs.sv
/* APB register block
   DATA pops the receive FIFO, STATUS reports flags, CTRL starts self-test */
`timescale 1ns/1ps
module apbRegs #(
        parameter int dataBits = 8
) (
        input logic clk,
        input logic rst,
        input logic psel,
        input logic penable,
        input logic pwrite,
        input logic [11:0] paddr,
        input logic [31:0] pwdata,
        output logic [31:0] prdata,
        output logic pready,
        output logic pslverr,
        fifoPortIf.regs port,
        input logic frameErr,
        input logic bistActive,
        input logic bistDone,
        input logic bistPass,
        output logic bistStart
);
        import uartRxPkg::*;

        logic access;                   // APB access phase
        logic rdAccess;
        logic mapped;
        logic frameErrSticky;
        logic [dataBits-1:0] headData;
        logic [7:0] status;

        assign access = psel && penable;
        assign rdAccess = access && !pwrite;
        assign mapped = paddr inside {ADDR_DATA, ADDR_STATUS, ADDR_CTRL};
        assign pready = 1'b1;                           // No wait states
        assign pslverr = access && !mapped;
        assign headData = port.empty ? '0 : port.rdData;        // Empty reads 0
        assign port.pop = rdAccess && (paddr == ADDR_DATA) && !port.empty;
        assign bistStart = access && pwrite && (paddr == ADDR_CTRL) && pwdata[0]
                           && !bistActive;

        ////////////////////////////////////////
        // Read path
        always_comb begin
                status = '0;
                status[ST_EMPTY] = port.empty;
                status[ST_HALF] = port.halfFull;
                status[ST_FULL] = port.full;
                status[ST_OVF] = port.overflow;
                status[ST_FRAMEERR] = frameErrSticky;
                status[ST_BISTBUSY] = bistActive;
                status[ST_BISTPASS] = bistPass;
                status[ST_BISTDONE] = bistDone;
        end

        always_comb begin
                prdata = '0;
                if (rdAccess) begin
                        case (paddr)
                        ADDR_DATA:   prdata = 32'(headData);
                        ADDR_STATUS: prdata = 32'(status);
                        ADDR_CTRL:   prdata = 32'(bistActive);
                        default:     prdata = '0;
                        endcase
                end
        end

        // Sticky frame error, a new error wins over the clearing read
        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        frameErrSticky <= 1'b0;
                else if (frameErr && !bistActive)       // Self-test frames not reported
                        frameErrSticky <= 1'b1;
                else if (rdAccess && paddr == ADDR_STATUS)
                        frameErrSticky <= 1'b0;
        end

endmodule

//--- verilog/uartRxTop.sv
/* UART receive path top level
   Receiver, self-test input mux, receive FIFO, self-test engine and APB registers */
`timescale 1ns/1ps
module uartRxTop #(
        parameter int dataBits = 8,
        parameter int fifoWidth = 4,
        parameter int clksPerBit = 16
) (
        input logic clk,
        input logic rst,
        input logic rxd,
        input logic psel,
        input logic penable,
        input logic pwrite,
        input logic [11:0] paddr,
        input logic [31:0] pwdata,
        output logic [31:0] prdata,
        output logic pready,
        output logic pslverr
);
        logic rxIn;
        logic [dataBits-1:0] rxData;
        logic rxValid;
        logic frameErr;
        logic bistTxd;
        logic bistActive;
        logic bistDone;
        logic bistPass;
        logic bistStart;

        fifoPortIf #(.dataBits(dataBits)) fifoPort ();

        assign rxIn = bistActive ? bistTxd : rxd;       // Loop back pattern in self-test

        uartRx #(.dataBits(dataBits), .clksPerBit(clksPerBit)) uartRx_inst (
                .clk(clk), .rst(rst), .rxIn(rxIn),
                .rxData(rxData), .rxValid(rxValid), .frameErr(frameErr));

        rxFifo #(.dataBits(dataBits), .fifoWidth(fifoWidth)) rxFifo_inst (
                .clk(clk), .rst(rst), .pushData(rxData), .push(rxValid),
                .freeze(bistActive), .port(fifoPort.fifo));

        fifoBist #(.clksPerBit(clksPerBit)) fifoBist_inst (
                .clk(clk), .rst(rst), .start(bistStart), .rxData(rxData),
                .rxValid(rxValid), .frameErr(frameErr), .txd(bistTxd),
                .active(bistActive), .done(bistDone), .pass(bistPass));

        apbRegs #(.dataBits(dataBits)) apbRegs_inst (
                .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
                .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
                .pslverr(pslverr), .port(fifoPort.regs), .frameErr(frameErr),
                .bistActive(bistActive), .bistDone(bistDone), .bistPass(bistPass),
                .bistStart(bistStart));

endmodule

//--- sim/uartRxTop_asserts.sv
/* Receive FIFO checker
   Flag consistency, freeze hold and overflow cause */
`timescale 1ns/1ps
module uartRxTop_asserts #(
        parameter int fifoWidth = 4
) (
        input logic clk,
        input logic rst,
        input logic push,
        input logic freeze,
        input logic empty,
        input logic halfFull,
        input logic full,
        input logic overflow,
        input logic [fifoWidth-1:0] wrPtr,
        input logic [fifoWidth-1:0] rdPtr,
        input logic [fifoWidth:0] count
);
        ////////////////////////////////////////
        // Occupancy flags
        emptyNotFull: assert property (@(posedge clk) disable iff (rst) !(empty && full))
                else $error("FIFO flags empty and full are both high");
        fullIsHalf: assert property (@(posedge clk) disable iff (rst) full |-> halfFull)
                else $error("FIFO full without halfFull");

        // Self-test freeze holds every register
        freezeHolds: assert property (@(posedge clk) disable iff (rst)
                freeze |=> $stable(count) && $stable(wrPtr) && $stable(rdPtr)
                        && $stable(empty) && $stable(halfFull) && $stable(full)
                        && $stable(overflow))
                else $error("FIFO register changed while frozen");

        // Overflow only from a push into a full FIFO
        ovfCause: assert property (@(posedge clk) disable iff (rst)
                $rose(overflow) |-> $past(push) && $past(full))
                else $error("FIFO overflow rose without a push into a full FIFO");

endmodule

bind rxFifo uartRxTop_asserts #(.fifoWidth(fifoWidth)) fifoAsserts_inst (
        .clk(clk), .rst(rst), .push(push), .freeze(freeze),
        .empty(port.empty), .halfFull(port.halfFull), .full(port.full),
        .overflow(port.overflow), .wrPtr(wrPtr), .rdPtr(rdPtr), .count(count));

//--- sim/uartRxTop_tb.sv
/* Testbench for the UART receive path
   Serial frames on rxd, APB register access, FIFO fill and self-test runs */
`timescale 1ns/1ps
module uartRxTop_tb;
        import uartRxPkg::*;

        localparam int clkPeriod = 20;
        localparam int bitClks = 16;            // Clocks per serial bit
        localparam int depth = 16;
        localparam int pollLimit = 40;          // STATUS reads before giving up
        localparam int bistPollLimit = 1000;    // Four frames at two cycles per read
        localparam logic [7:0] emptyMask = 8'(1 << ST_EMPTY);
        localparam logic [7:0] ferrMask = 8'(1 << ST_FRAMEERR);
        localparam logic [7:0] doneMask = 8'(1 << ST_BISTDONE);
        localparam logic [7:0] keep [3] = '{8'h12, 8'h34, 8'h56};      // Held across self-test

        typedef struct packed {
                logic [7:0] data;
                logic stopBit;
                logic [7:0] statusFrame;        // STATUS once the frame is in
                logic [7:0] readData;           // Expected DATA read
        } frameVec_t;

        // Bad stop bit row adds no entry, so DATA reads 0
        localparam frameVec_t vecs [6] = '{
                '{8'h00, 1'b1, 8'h00, 8'h00},
                '{8'hFF, 1'b1, 8'h00, 8'hFF},
                '{8'hA5, 1'b1, 8'h00, 8'hA5},
                '{8'h3C, 1'b0, emptyMask | ferrMask, 8'h00},
                '{8'h81, 1'b1, 8'h00, 8'h81},
                '{8'h7E, 1'b1, 8'h00, 8'h7E}};

        logic clk, rst, rxd, psel, penable, pwrite, pready, pslverr;
        logic [11:0] paddr;
        logic [31:0] pwdata, prdata;
        logic [31:0] lfsr;

        uartRxTop uartRxTop_inst (
                .clk(clk), .rst(rst), .rxd(rxd), .psel(psel), .penable(penable),
                .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
                .pready(pready), .pslverr(pslverr));

        initial begin
                clk = 1'b0;
                forever #(clkPeriod / 2) clk = ~clk;
        end

        task automatic failRun(input string why);
                $display("%s", why);
                $display("TESTBENCH FAILED");
                $fatal(1);
        endtask

        task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] want);
                assert (got === want)
                else failRun($sformatf("[FAIL] t=%0t %s: got 0x%0h expected 0x%0h",
                        $time, name, got, want));
        endtask

        ////////////////////////////////////////
        // APB master, called and returning on a falling edge
        task automatic apbRead(input logic [11:0] addr, output logic [31:0] data, output logic err);
                psel = 1'b1;                    // Setup phase
                pwrite = 1'b0;
                paddr = addr;
                @(negedge clk);
                penable = 1'b1;                 // Access phase
                #(clkPeriod / 4);
                data = prdata;
                err = pslverr;
                checkEq("pready", 32'(pready), 32'd1);
                @(negedge clk);
                psel = 1'b0;
                penable = 1'b0;
        endtask

        task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, output logic err);
                psel = 1'b1;
                pwrite = 1'b1;
                paddr = addr;
                pwdata = data;
                @(negedge clk);
                penable = 1'b1;
                #(clkPeriod / 4) err = pslverr;
                @(negedge clk);
                psel = 1'b0;
                penable = 1'b0;
                pwrite = 1'b0;
        endtask

        // Start bit, 8 data bits LSB first, stop bit, one idle bit
        task automatic sendFrame(input logic [7:0] data, input logic stopBit);
                int i;
                rxd = 1'b0;
                repeat (bitClks) @(negedge clk);
                for (i = 0; i < 8; i++) begin
                        rxd = data[i];
                        repeat (bitClks) @(negedge clk);
                end
                rxd = stopBit;
                repeat (bitClks) @(negedge clk);
                rxd = 1'b1;
                repeat (bitClks) @(negedge clk);
        endtask

        task automatic waitStatus(input logic [7:0] mask, input logic [7:0] want, input int limit,
                        output logic [31:0] last);
                int polls;
                logic err;
                polls = 0;
                apbRead(ADDR_STATUS, last, err);
                while (((last[7:0] & mask) != want) && polls < limit) begin
                        polls++;
                        apbRead(ADDR_STATUS, last, err);
                end
                if ((last[7:0] & mask) != want)
                        failRun($sformatf("Timed out waiting for STATUS bits 0x%02h to read 0x%02h",
                                mask, want));
        endtask

        // Status word from the register map rules, self-test idle
        function automatic logic [7:0] expStatus(input int entries, input logic ovf,
                        input logic pass, input logic done);
                logic [7:0] s;
                s = '0;
                s[ST_EMPTY] = (entries == 0);
                s[ST_HALF] = (entries >= depth / 2);
                s[ST_FULL] = (entries == depth);
                s[ST_OVF] = ovf;
                s[ST_BISTPASS] = pass;
                s[ST_BISTDONE] = done;
                return s;
        endfunction

        function automatic logic [31:0] lfsrStep(input logic [31:0] s);
                return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);   // Galois, right shift
        endfunction

        task automatic nextByte(output logic [7:0] b);
                int i;
                for (i = 0; i < 8; i++) begin
                        b[i] = lfsr[0];
                        lfsr = lfsrStep(lfsr);
                end
        endtask

        initial begin
                logic [31:0] rd, st;
                logic err;
                logic [7:0] sent [17];
                logic [7:0] expS;
                int n, stored;
                rst = 1'b1;
                rxd = 1'b1;             // Line idles high
                psel = 1'b0;
                penable = 1'b0;
                pwrite = 1'b0;
                paddr = '0;
                pwdata = '0;
                lfsr = 32'hecba_9792;
                repeat (5) @(negedge clk);
                rst = 1'b0;
                @(negedge clk);

                ////////////////////////////////////////
                // Reset state and unmapped address
                apbRead(ADDR_STATUS, st, err);
                checkEq("STATUS", st, 32'(emptyMask));
                apbRead(ADDR_DATA, rd, err);
                checkEq("DATA", rd, 32'd0);
                checkEq("pslverr", 32'(err), 32'd0);
                apbRead(12'h00C, rd, err);
                checkEq("pslverr", 32'(err), 32'd1);

                // Single frames from the table, frame error row included
                for (n = 0; n < 6; n++) begin
                        sendFrame(vecs[n].data, vecs[n].stopBit);
                        waitStatus(emptyMask | ferrMask, vecs[n].statusFrame, pollLimit, st);
                        checkEq("STATUS", st, 32'(vecs[n].statusFrame));
                        apbRead(ADDR_DATA, rd, err);
                        checkEq("DATA", rd, 32'(vecs[n].readData));
                        apbRead(ADDR_STATUS, st, err);
                        checkEq("STATUS", st, 32'(expStatus(0, 1'b0, 1'b0, 1'b0)));
                end

                ////////////////////////////////////////
                // Fill to full, seventeenth byte overflows and is lost
                for (n = 0; n < 17; n++) begin
                        nextByte(sent[n]);
                        sendFrame(sent[n], 1'b1);
                        stored = (n < depth) ? n + 1 : depth;
                        expS = expStatus(stored, n == depth, 1'b0, 1'b0);
                        waitStatus(8'h0F, expS, pollLimit, st);        // Occupancy and overflow
                        checkEq("STATUS", st, 32'(expS));
                end
                for (n = 0; n < depth; n++) begin
                        apbRead(ADDR_DATA, rd, err);
                        checkEq("DATA", rd, 32'(sent[n]));
                        apbRead(ADDR_STATUS, st, err);
                        checkEq("STATUS", st, 32'(expStatus(depth - 1 - n, 1'b0, 1'b0, 1'b0)));
                end
                apbRead(ADDR_DATA, rd, err);
                checkEq("DATA", rd, 32'd0);

                ////////////////////////////////////////
                // Self-test with three bytes held in the FIFO
                for (n = 0; n < 3; n++) begin
                        sendFrame(keep[n], 1'b1);
                        waitStatus(emptyMask, 8'h00, pollLimit, st);
                end
                apbWrite(ADDR_CTRL, 32'h1, err);
                checkEq("pslverr", 32'(err), 32'd0);
                apbRead(ADDR_STATUS, st, err);
                checkEq("STATUS busy", 32'(st[ST_BISTBUSY]), 32'd1);
                waitStatus(doneMask, doneMask, bistPollLimit, st);
                checkEq("STATUS", st, 32'(expStatus(3, 1'b0, 1'b1, 1'b1)));

                // Second run with a frame on rxd that must be ignored
                apbWrite(ADDR_CTRL, 32'h1, err);
                sendFrame(8'hC3, 1'b1);
                waitStatus(doneMask, doneMask, bistPollLimit, st);
                checkEq("STATUS", st, 32'(expStatus(3, 1'b0, 1'b1, 1'b1)));
                for (n = 0; n < 3; n++) begin
                        apbRead(ADDR_DATA, rd, err);
                        checkEq("DATA", rd, 32'(keep[n]));
                end
                apbRead(ADDR_DATA, rd, err);            // No pattern byte left behind
                checkEq("DATA", rd, 32'd0);
                apbRead(ADDR_STATUS, st, err);
                checkEq("STATUS", st, 32'(expStatus(0, 1'b0, 1'b1, 1'b1)));

                $display("TESTBENCH PASSED");
                $finish;
        end

endmodule

//--- uartRxTop.f
verilog/uartRxPkg.sv
verilog/fifoPortIf.sv
verilog/uartRx.sv
verilog/rxFifo.sv
verilog/fifoBist.sv
verilog/apbRegs.sv
verilog/uartRxTop.sv
sim/uartRxTop_asserts.sv
sim/uartRxTop_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the UART receive path with Verilator and run the testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module uartRxTop_tb -f uartRxTop.f -o simv \
        && ./obj_dir/simv \
        || { echo "Build or simulation returned an error"; exit 1; }
